// File: hw/alu_unit.sv
// single-cycle alu and pipelined multiplier on one result bus
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module alu_unit import ooo_pkg::*; (
	input  logic   clock,
	input  logic   arst_n,
	input  logic   issue_valid,
	input  issue_t issue,
	output logic   mul_busy_next,
	output logic   cdb_valid,
	output cdb_t   cdb
);

	localparam int DW = `OOO_DATA_W;
	localparam int LAT = `OOO_MUL_LAT;

	logic [DW-1:0] opa_ext;
	logic [DW-1:0] opb_ext;
	logic [DW-1:0] alu_res;
	logic is_mul;
	logic res_valid;
	tag_t res_tag;
	logic [DW-1:0] res_data;
	logic [LAT-1:0] mul_v;
	tag_t mul_tag [LAT];
	logic [DW-1:0] mul_data [LAT];

	// immediates are zero extended
	assign opa_ext = DW'(issue.opa);
	assign opb_ext = DW'(issue.opb);
	assign is_mul = (issue.op == OP_MUL);

	always_comb begin
		case (issue.op)
			OP_ADD: alu_res = opa_ext + opb_ext;
			OP_SUB: alu_res = opa_ext - opb_ext;
			OP_AND: alu_res = opa_ext & opb_ext;
			OP_OR: alu_res = opa_ext | opb_ext;
			OP_XOR: alu_res = opa_ext ^ opb_ext;
			OP_SHL: alu_res = opa_ext << opb_ext[4:0];
			// low word of the product
			OP_MUL: alu_res = opa_ext * opb_ext;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
			mul_v <= '0;
		end else begin
			res_valid <= issue_valid & ~is_mul;
			mul_v <= {mul_v[LAT-2:0], issue_valid & is_mul};
		end
	end

	// tags and data shift with the valid bits
	always_ff @(posedge clock) begin
		res_tag <= issue.tag;
		res_data <= alu_res;
		mul_tag[0] <= issue.tag;
		mul_data[0] <= alu_res;
		for (int k = 1; k < LAT; k++) begin
			mul_tag[k] <= mul_tag[k-1];
			mul_data[k] <= mul_data[k-1];
		end
	end

	// station looks at this before issuing a single-cycle op
	assign mul_busy_next = mul_v[LAT-2];

	assign cdb_valid = mul_v[LAT-1] | res_valid;
	assign cdb = mul_v[LAT-1] ? cdb_t'{tag: mul_tag[LAT-1], data: mul_data[LAT-1]}
	                          : cdb_t'{tag: res_tag, data: res_data};

endmodule

`default_nettype wire

// File: hw/ooo_cfg.svh
// width and depth macros for the out-of-order execution slice
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// result bus, commit and wishbone data
`define OOO_DATA_W 32
// immediate operands inside the instruction word
`define OOO_OPND_W 12
// destination register index
`define OOO_REG_W 5

////////////////////////////////////////////////////////////
// structure sizes
////////////////////////////////////////////////////////////

// reorder buffer entries, tag must cover them
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W 3
`define OOO_RS_DEPTH 4
// cycles from mul issue to result bus
`define OOO_MUL_LAT 3

`endif

// File: hw/ooo_core.sv
// top level, dispatch feeds station and rob, alu results return on one bus
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_core import ooo_pkg::*; (
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`OOO_DATA_W-1:0]  wb_dat_w,
	output logic                    wb_ack,
	output logic [`OOO_DATA_W-1:0]  wb_dat_r,
	output logic                    commit_valid,
	output logic [`OOO_REG_W-1:0]   commit_rd,
	output logic [`OOO_DATA_W-1:0]  commit_data,
	output logic                    commit_error
);

	// dispatch to rob
	logic rob_full;
	tag_t alloc_tag;
	logic alloc_valid;
	logic [`OOO_REG_W-1:0] alloc_rd;
	logic alloc_illegal;
	// dispatch to station
	logic rs_full;
	logic rs_load;
	issue_t rs_entry;
	// station to alu
	logic issue_valid;
	issue_t issue;
	logic mul_busy_next;
	// result bus
	logic cdb_valid;
	cdb_t cdb;

	wb_dispatch dispatch_i (
		.clock, .arst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_dat_w,
		.rob_full, .rs_full, .alloc_tag, .commit_valid,
		.wb_ack, .wb_dat_r,
		.alloc_valid, .alloc_rd, .alloc_illegal,
		.rs_load, .rs_entry
	);

	res_station station_i (
		.clock, .arst_n,
		.rs_load, .rs_entry, .mul_busy_next,
		.rs_full, .issue_valid, .issue
	);

	alu_unit alu_i (
		.clock, .arst_n,
		.issue_valid, .issue,
		.mul_busy_next, .cdb_valid, .cdb
	);

	reorder_buf rob_i (
		.clock, .arst_n,
		.alloc_valid, .alloc_rd, .alloc_illegal,
		.cdb_valid, .cdb,
		.rob_full, .alloc_tag,
		.commit_valid, .commit_rd, .commit_data, .commit_error
	);

endmodule

`default_nettype wire

// File: hw/ooo_pkg.sv
// opcode, tag, instruction word, issue and result bus types
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

	// opcodes, top three bits of the word
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SHL = 3'd5,
		OP_MUL = 3'd6,
		OP_ILL = 3'd7
	} op_e;

	// reorder buffer index
	typedef logic [`OOO_TAG_W-1:0] tag_t;

	// instruction word as written over wishbone
	typedef struct packed {
		op_e                    op;
		logic [`OOO_REG_W-1:0]  rd;
		logic [`OOO_OPND_W-1:0] opa;
		logic [`OOO_OPND_W-1:0] opb;
	} instr_t;

	// station entry, also what goes to the alu
	typedef struct packed {
		op_e                    op;
		logic [`OOO_OPND_W-1:0] opa;
		logic [`OOO_OPND_W-1:0] opb;
		tag_t                   tag;
	} issue_t;

	// one result on the common bus
	typedef struct packed {
		tag_t                   tag;
		logic [`OOO_DATA_W-1:0] data;
	} cdb_t;

endpackage

`default_nettype wire

// File: hw/reorder_buf.sv
// circular reorder buffer, results written by tag, retired in order
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module reorder_buf import ooo_pkg::*; (
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    alloc_valid,
	input  logic [`OOO_REG_W-1:0]   alloc_rd,
	input  logic                    alloc_illegal,
	input  logic                    cdb_valid,
	input  cdb_t                    cdb,
	output logic                    rob_full,
	output tag_t                    alloc_tag,
	output logic                    commit_valid,
	output logic [`OOO_REG_W-1:0]   commit_rd,
	output logic [`OOO_DATA_W-1:0]  commit_data,
	output logic                    commit_error
);

	localparam int DEPTH = `OOO_ROB_DEPTH;

	tag_t head;
	tag_t tail;
	logic [`OOO_TAG_W:0] count;
	logic [DEPTH-1:0] done;
	logic [`OOO_REG_W-1:0] rd_mem [DEPTH];
	logic err_mem [DEPTH];
	logic [`OOO_DATA_W-1:0] data_mem [DEPTH];
	logic retire;

	assign rob_full = (count == DEPTH);
	assign alloc_tag = tail;
	// count check keeps stale done bits of freed slots out
	assign retire = (count != '0) & done[head];

	////////////////////////////////////////////////////////////
	// pointers, done bits, commit port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
			commit_valid <= 1'b0;
			commit_rd <= '0;
			commit_data <= '0;
			commit_error <= 1'b0;
		end else begin
			// illegal entries are complete as soon as they arrive
			if (alloc_valid) begin
				done[tail] <= alloc_illegal;
				tail <= tail + 1'b1;
			end
			if (cdb_valid)
				done[cdb.tag] <= 1'b1;
			commit_valid <= retire;
			if (retire) begin
				commit_rd <= rd_mem[head];
				// error entries report zero data
				commit_data <= err_mem[head] ? '0 : data_mem[head];
				commit_error <= err_mem[head];
				head <= head + 1'b1;
			end
			count <= count + alloc_valid - retire;
		end
	end

	////////////////////////////////////////////////////////////
	// entry payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (alloc_valid) begin
			rd_mem[tail] <= alloc_rd;
			err_mem[tail] <= alloc_illegal;
		end
		if (cdb_valid)
			data_mem[cdb.tag] <= cdb.data;
	end

endmodule

`default_nettype wire

// File: hw/res_station.sv
// reservation station, operands are immediates so every entry is ready
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module res_station import ooo_pkg::*; (
	input  logic   clock,
	input  logic   arst_n,
	input  logic   rs_load,
	input  issue_t rs_entry,
	input  logic   mul_busy_next,
	output logic   rs_full,
	output logic   issue_valid,
	output issue_t issue
);

	localparam int DEPTH = `OOO_RS_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	logic [DEPTH-1:0] valid;
	issue_t slot [DEPTH];
	logic [DEPTH-1:0] eligible;
	logic [IDX_W-1:0] pick_idx;
	logic [IDX_W-1:0] free_idx;

	assign rs_full = &valid;

	////////////////////////////////////////////////////////////
	// issue select
	////////////////////////////////////////////////////////////

	// single-cycle result would land on the mul result,
	// so only a mul may go while the pipe is about to drain
	always_comb begin
		for (int i = 0; i < DEPTH; i++)
			eligible[i] = valid[i] & (~mul_busy_next | (slot[i].op == OP_MUL));
	end

	// lowest index wins, scan from the top down
	always_comb begin
		pick_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--)
			if (eligible[i])
				pick_idx = IDX_W'(i);
	end

	assign issue_valid = |eligible;
	assign issue = slot[pick_idx];

	// lowest empty slot for the incoming entry
	always_comb begin
		free_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--)
			if (!valid[i])
				free_idx = IDX_W'(i);
	end

	////////////////////////////////////////////////////////////
	// entry state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else begin
			// issued slot is always a valid one, free slot never is
			if (issue_valid)
				valid[pick_idx] <= 1'b0;
			if (rs_load)
				valid[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rs_load)
			slot[free_idx] <= rs_entry;
	end

endmodule

`default_nettype wire

// File: hw/wb_dispatch.sv
// wishbone classic slave, instruction decode and allocation
// also keeps the committed instruction counter
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module wb_dispatch import ooo_pkg::*; (
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`OOO_DATA_W-1:0]  wb_dat_w,
	input  logic                    rob_full,
	input  logic                    rs_full,
	input  tag_t                    alloc_tag,
	input  logic                    commit_valid,
	output logic                    wb_ack,
	output logic [`OOO_DATA_W-1:0]  wb_dat_r,
	output logic                    alloc_valid,
	output logic [`OOO_REG_W-1:0]   alloc_rd,
	output logic                    alloc_illegal,
	output logic                    rs_load,
	output issue_t                  rs_entry
);

	instr_t word;
	logic req;
	logic can_write;
	logic accept;
	logic [`OOO_DATA_W-1:0] commit_cnt;

	assign word = instr_t'(wb_dat_w);
	// ack cycle is masked, so one strobe gives one allocation
	assign req = wb_cyc & wb_stb & ~wb_ack;
	// illegal words skip the station, only need a rob slot
	assign can_write = ~rob_full & (alloc_illegal | ~rs_full);
	assign accept = req & (~wb_we | can_write);

	assign alloc_illegal = (word.op == OP_ILL);
	assign alloc_valid = req & wb_we & can_write;
	assign alloc_rd = word.rd;
	assign rs_load = alloc_valid & ~alloc_illegal;
	assign rs_entry = issue_t'{op: word.op, opa: word.opa, opb: word.opb, tag: alloc_tag};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
			wb_dat_r <= '0;
			commit_cnt <= '0;
		end else begin
			wb_ack <= accept;
			// reads sample the count, writes leave it alone
			if (accept && !wb_we)
				wb_dat_r <= commit_cnt;
			if (commit_valid)
				commit_cnt <= commit_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/ooo_pkg.sv
hw/wb_dispatch.sv
hw/res_station.sv
hw/alu_unit.sv
hw/reorder_buf.sv
hw/ooo_core.sv
tb/ooo_sva.sv
tb/ooo_tb.sv

// File: tb/ooo_sva.sv
// wishbone ack and commit port assertions, bound into ooo_core
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_sva (
	input wire logic                   clock,
	input wire logic                   arst_n,
	input wire logic                   wb_cyc,
	input wire logic                   wb_stb,
	input wire logic                   wb_ack,
	input wire logic                   commit_valid,
	input wire logic [`OOO_REG_W-1:0]  commit_rd,
	input wire logic [`OOO_DATA_W-1:0] commit_data,
	input wire logic                   commit_error
);

	int fail_count = 0;

	// ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
	else begin
		$error("wb_ack high for more than one cycle");
		fail_count++;
	end

	// registered ack answers a request from the cycle before
	ack_after_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
	else begin
		$error("wb_ack without a preceding cyc and stb");
		fail_count++;
	end

	commit_known: assert property (@(posedge clock) disable iff (!arst_n)
		!$isunknown({commit_valid, commit_rd, commit_data, commit_error}))
	else begin
		$error("commit port carries unknown bits");
		fail_count++;
	end

endmodule

bind ooo_core ooo_sva sva_i (.*);

`default_nettype wire

// File: tb/ooo_tb.sv
// testbench for ooo_core with wishbone driver tasks, commit reference queue,
// compare tasks and directed tests
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_tb import ooo_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS + 1000;
	localparam int DW = `OOO_DATA_W;
	localparam int OW = `OOO_OPND_W;
	localparam int RW = `OOO_REG_W;

	logic clock;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [DW-1:0] wb_dat_w;
	logic wb_ack;
	logic [DW-1:0] wb_dat_r;
	logic commit_valid;
	logic [RW-1:0] commit_rd;
	logic [DW-1:0] commit_data;
	logic commit_error;

	// expected commits, oldest at the front
	logic [RW-1:0] exp_rd [$];
	logic [DW-1:0] exp_data [$];
	logic exp_err [$];
	int errors = 0;
	int n_written = 0;
	int n_commits = 0;
	int n_tests = 0;

	ooo_core dut_i (.*);

	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// reference rule and compare tasks
	////////////////////////////////////////////////////////////

	function automatic logic [DW-1:0] ref_result(op_e op, logic [OW-1:0] a, logic [OW-1:0] b);
		logic [DW-1:0] xa;
		logic [DW-1:0] xb;
		xa = DW'(a);
		xb = DW'(b);
		case (op)
			OP_ADD: return xa + xb;
			OP_SUB: return xa - xb;
			OP_AND: return xa & xb;
			OP_OR: return xa | xb;
			OP_XOR: return xa ^ xb;
			OP_SHL: return xa << xb[4:0];
			OP_MUL: return xa * xb;
			default: return '0;
		endcase
	endfunction

	task automatic check_data(input string name, input logic [DW-1:0] got, input logic [DW-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_rd(input string name, input logic [RW-1:0] got, input logic [RW-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [DW-1:0] got, input logic [DW-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// commit monitor, outputs are stable on the falling edge
	always @(negedge clock) begin
		if (arst_n && commit_valid) begin
			n_commits++;
			if (exp_rd.size() == 0) begin
				$display("commit at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				check_rd("commit_rd", commit_rd, exp_rd.pop_front());
				check_data("commit_data", commit_data, exp_data.pop_front());
				check_err("commit_error", commit_error, exp_err.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// wishbone driver
	////////////////////////////////////////////////////////////

	task automatic wb_write(input op_e op, input logic [RW-1:0] rd,
			input logic [OW-1:0] a, input logic [OW-1:0] b);
		instr_t word;
		word = '{op: op, rd: rd, opa: a, opb: b};
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_dat_w = word;
		do @(negedge clock); while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		exp_rd.push_back(rd);
		exp_data.push_back(ref_result(op, a, b));
		exp_err.push_back(op == OP_ILL);
		n_written++;
	endtask

	task automatic wb_read(output logic [DW-1:0] data);
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		do @(negedge clock); while (!wb_ack);
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// all accepted writes have committed
	task automatic wait_drain();
		while (exp_rd.size() != 0)
			@(posedge clock);
	endtask

	task automatic write_random(input op_e op);
		wb_write(op, RW'($urandom()), OW'($urandom()), OW'($urandom()));
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (errors == errs_before)
			$display("test %0d %s: ok", n_tests, name);
		else
			$display("test %0d %s: %0d errors", n_tests, name, errors - errs_before);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_each_op();
		int e0;
		e0 = errors;
		for (int op = 0; op < 7; op++)
			write_random(op_e'(3'(op)));
		wait_drain();
		report_test("each legal op", e0);
	endtask

	// adds overtake the mul in the alu, commits stay in order
	task automatic test_mul_then_adds();
		int e0;
		e0 = errors;
		wb_write(OP_MUL, 5'd7, 12'hfff, OW'($urandom()));
		for (int i = 0; i < 4; i++)
			write_random(OP_ADD);
		wait_drain();
		report_test("mul then adds", e0);
	endtask

	task automatic test_illegal();
		int e0;
		e0 = errors;
		write_random(OP_ADD);
		write_random(OP_ILL);
		write_random(OP_XOR);
		wait_drain();
		report_test("illegal opcode", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		int c0;
		e0 = errors;
		c0 = n_commits;
		for (int i = 0; i < 12; i++)
			write_random(op_e'(3'($urandom_range(0, 7))));
		wait_drain();
		check_count("commits", DW'(n_commits - c0), DW'(12));
		report_test("back to back writes", e0);
	endtask

	task automatic test_read_count();
		int e0;
		logic [DW-1:0] cnt;
		e0 = errors;
		wb_read(cnt);
		check_count("wb_dat_r", cnt, DW'(n_written));
		report_test("committed count read", e0);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	initial begin
		void'($urandom(82));
		clock = 1'b0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_dat_w = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		test_each_op();
		test_mul_then_adds();
		test_illegal();
		test_backpressure();
		test_read_count();
		repeat (4) @(posedge clock);
		errors += dut_i.sva_i.fail_count;
		$display("%0d tests, %0d commits, %0d errors", n_tests, n_commits, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
